// File: dct2d_top.f
+incdir+sim
hw/dct2d_pkg.sv
hw/dct_butterfly_mac.sv
hw/dct_row_seq.sv
hw/transpose_ram.sv
hw/dct_col_seq.sv
hw/dct2d_top.sv
sim/dct2d_tb.sv

// File: Bender.yml
package:
  name: dct2d_top

sources:
  - files:
      - hw/dct2d_pkg.sv
      - hw/dct_butterfly_mac.sv
      - hw/dct_row_seq.sv
      - hw/transpose_ram.sv
      - hw/dct_col_seq.sv
      - hw/dct2d_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/dct2d_tb.sv

// File: sim/dct2d_model.svh
/* 2-D DCT reference model */
`ifndef DCT2D_MODEL_SVH
`define DCT2D_MODEL_SVH

typedef int blk_t [64];   // 8x8 block, row-major in, column-major out

// cos(i*pi/16) scaled by 2^16
function automatic int cos16(input int i);
    case (i)
        1:       return 64277;
        2:       return 60547;
        3:       return 54491;
        4:       return 46341;
        5:       return 36410;
        6:       return 25080;
        7:       return 12785;
        default: return 0;
    endcase
endfunction

// signed basis weight for output k, butterfly term j
function automatic int basis(input int k, input int j);
    int m;
    if (k == 0) begin
        return 46341;                 // dc scaled by 1/sqrt2
    end
    m = ((2 * j + 1) * k) % 32;       // angle in pi/16 steps
    if (m > 16) begin
        m = 32 - m;                   // cos symmetry
    end
    if (m > 8) begin
        return -cos16(16 - m);        // second quadrant
    end
    return cos16(m);
endfunction

// one 1-D output with sign-magnitude products and rounding
function automatic int dct_point(input int s[8], input int k, input int prod_shift,
                                 input int rnd_bits, input int res_w);
    longint sum;
    longint a;
    longint c;
    longint p;
    longint r;
    sum = 0;
    for (int j = 0; j < 4; j++) begin
        a = (k % 2 == 0) ? longint'(s[j]) + s[7-j] : longint'(s[j]) - s[7-j];
        c = basis(k, j);
        p = ((a < 0 ? -a : a) * (c < 0 ? -c : c)) >> prod_shift;   // floor of magnitude
        if ((a < 0) != (c < 0)) begin
            p = -p;
        end
        sum += p;
    end
    r = (sum >>> rnd_bits) + ((sum >>> (rnd_bits - 1)) & 1);   // round half up
    r = r & ((64'sd1 << res_w) - 1);                             // wrap to result width
    if (r >= (64'sd1 << (res_w - 1))) begin
        r -= (64'sd1 << res_w);
    end
    return int'(r);
endfunction

// rows first, then columns of the row results
function automatic blk_t dct2d_model(input blk_t pix);
    int   rows [8][8];
    int   s    [8];
    blk_t res;
    for (int r = 0; r < 8; r++) begin
        for (int i = 0; i < 8; i++) s[i] = pix[r*8 + i];
        for (int k = 0; k < 8; k++) begin
            rows[r][k] = dct_point(s, k, dct2d_pkg::ROW_SHIFT, dct2d_pkg::ROW_RND,
                                   dct2d_pkg::ROW_W);
        end
    end
    for (int c = 0; c < 8; c++) begin
        for (int i = 0; i < 8; i++) s[i] = rows[i][c];
        for (int k = 0; k < 8; k++) begin
            res[c*8 + k] = dct_point(s, k, dct2d_pkg::COL_SHIFT, dct2d_pkg::COL_RND,
                                     dct2d_pkg::OUT_W);
        end
    end
    return res;
endfunction

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;   // numerical recipes constants
endfunction

`endif

// File: sim/dct2d_tb.sv
/* 2-D DCT testbench */
`timescale 1ns/1ps

module dct2d_tb;

    localparam int CLK_PERIOD       = 100;
    localparam int NUM_BLOCKS       = 9;
    localparam int IDLE_CYCLES      = 6;     // quiet time after reset
    localparam int CYCLES_PER_BLOCK = 200;
    localparam int WATCHDOG_CYCLES  = NUM_BLOCKS * CYCLES_PER_BLOCK + IDLE_CYCLES + 100;

    typedef enum logic [2:0] {
        PAT_ZERO, PAT_CONST, PAT_HRAMP, PAT_VRAMP, PAT_CHECKER, PAT_EXTREME, PAT_RANDOM
    } pat_kind_e;

    typedef struct packed {
        pat_kind_e  kind;
        logic [7:0] gap;    // idle cycles after the block
    } block_entry_t;

    localparam block_entry_t BLOCK_TABLE [NUM_BLOCKS] = '{
        '{PAT_ZERO,    8'd0},   // back to back
        '{PAT_CONST,   8'd0},
        '{PAT_HRAMP,   8'd3},
        '{PAT_VRAMP,   8'd0},
        '{PAT_CHECKER, 8'd0},
        '{PAT_EXTREME, 8'd5},
        '{PAT_RANDOM,  8'd0},
        '{PAT_RANDOM,  8'd9},
        '{PAT_CONST,   8'd4}    // same block again after a gap
    };

    `include "dct2d_model.svh"

    logic                                 clk;
    logic                                 i_rst_n;
    logic                                 i_start;
    logic signed [dct2d_pkg::PIXEL_W-1:0] i_pixel;
    logic signed [dct2d_pkg::OUT_W-1:0]   o_coef;
    logic                                 o_valid;
    logic                                 o_first_next;

    logic [31:0] lcg_state;
    blk_t        pix_buf;
    blk_t        exp_blk;
    int          exp_q [$];          // expected coefficients in column-major order
    int          blocks_done = 0;
    int          out_idx     = 0;    // position within current output block
    logic        prev_first  = 1'b0;

    dct2d_top dut0 (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_pixel      (i_pixel),
        .o_coef       (o_coef),
        .o_valid      (o_valid),
        .o_first_next (o_first_next)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task check_coef(input logic signed [dct2d_pkg::OUT_W-1:0] got,
                    input logic signed [dct2d_pkg::OUT_W-1:0] exp, input int blk, input int idx);
        if (got !== exp) begin
            $display("ERROR %0t: block %0d output %0d is %0d, expected %0d",
                     $time, blk, idx, got, exp);
            abort_run();
        end
    endtask

    task check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task build_block(input pat_kind_e kind);
        int r;
        int c;
        for (int n = 0; n < 64; n++) begin
            r = n / 8;
            c = n % 8;
            case (kind)
                PAT_ZERO:    pix_buf[n] = 0;
                PAT_CONST:   pix_buf[n] = 137;
                PAT_HRAMP:   pix_buf[n] = c * 60 - 210;   // varies along a row
                PAT_VRAMP:   pix_buf[n] = r * 70 - 245;   // varies down a column
                PAT_CHECKER: pix_buf[n] = ((r + c) % 2 == 1) ? -300 : 300;
                PAT_EXTREME: pix_buf[n] = (((r ^ c) & 2) != 0) ? -511 : 511;
                default: begin
                    lcg_state  = lcg_next(lcg_state);
                    pix_buf[n] = $signed(lcg_state[25:16]);   // full 10-bit range
                end
            endcase
        end
    endtask

    task drive_block(input int gap);
        for (int n = 0; n < 64; n++) begin
            @(posedge clk);
            i_start <= (n == 0);   // start comes with pixel 0
            i_pixel <= pix_buf[n][dct2d_pkg::PIXEL_W-1:0];
        end
        repeat (gap) begin
            @(posedge clk);
            i_start <= 1'b0;
            i_pixel <= '0;
        end
    endtask

    // stimulus
    initial begin
        i_rst_n   = 1'b0;
        i_start   = 1'b0;
        i_pixel   = '0;
        lcg_state = 32'h4f3156a6;
        repeat (2) @(posedge clk);
        i_rst_n <= 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk);   // outputs must stay quiet here
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            build_block(BLOCK_TABLE[b].kind);
            exp_blk = dct2d_model(pix_buf);
            for (int n = 0; n < 64; n++) begin
                if (BLOCK_TABLE[b].kind == PAT_CONST && n != 0) begin
                    exp_q.push_back(0);   // flat block has only dc
                end else begin
                    exp_q.push_back(exp_blk[n]);
                end
            end
            drive_block(BLOCK_TABLE[b].gap);
        end
        @(posedge clk);
        i_start <= 1'b0;
        i_pixel <= '0;
        wait (blocks_done == NUM_BLOCKS);
        repeat (20) @(posedge clk);   // no stray valid afterwards
        $display("Simulation completed successfully");
        $finish;
    end

    // output monitor sampled mid-cycle
    always @(negedge clk) begin
        logic signed [dct2d_pkg::OUT_W-1:0] exp_coef;
        int                                 exp_val;
        if (i_rst_n) begin
            if (exp_q.size() == 0) begin
                check_flag(o_valid, 1'b0, "o_valid with no block pending");
                check_flag(o_first_next, 1'b0, "o_first_next with no block pending");
            end else begin
                if (prev_first) check_flag(o_valid, 1'b1, "o_valid after o_first_next");
                if (out_idx != 0) check_flag(o_valid, 1'b1, "o_valid inside a block");
                if (o_valid) begin
                    check_flag(prev_first, out_idx == 0, "o_first_next one cycle before");
                    exp_val  = exp_q.pop_front();
                    exp_coef = exp_val[dct2d_pkg::OUT_W-1:0];
                    check_coef(o_coef, exp_coef, blocks_done, out_idx);
                    if (out_idx == 63) begin
                        out_idx = 0;
                        blocks_done++;
                    end else begin
                        out_idx++;
                    end
                end
            end
            prev_first = o_first_next;
        end
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: only %0d of %0d blocks came out before the time limit",
                 blocks_done, NUM_BLOCKS);
        abort_run();
    end

endmodule

// File: hw/dct2d_top.sv
/* 8x8 2-D DCT top */
`timescale 1ns/1ps

module dct2d_top (
    input  logic                                clk,
    input  logic                                i_rst_n,
    input  logic                                i_start,    // with pixel 0
    input  logic signed [dct2d_pkg::PIXEL_W-1:0] i_pixel,
    output logic signed [dct2d_pkg::OUT_W-1:0]   o_coef,
    output logic                                o_valid,
    output logic                                o_first_next
);

    dct2d_pkg::mac_ctl_t                 row_ctl;
    dct2d_pkg::mac_ctl_t                 col_ctl;
    dct2d_pkg::tm_wr_t                   tm_wr;
    dct2d_pkg::tm_rd_t                   tm_rd;
    logic signed [dct2d_pkg::ROW_W-1:0]  row_coef;   // row pass result
    logic signed [dct2d_pkg::ROW_W-1:0]  tm_rdata;   // transposed stream
    logic                                page_done;
    logic                                page;

    dct_row_seq row_seq (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .o_mac_ctl   (row_ctl),
        .o_tm_wr     (tm_wr),
        .o_page_done (page_done),
        .o_page      (page)
    );

    dct_butterfly_mac #(
        .SAMPLE_W   (dct2d_pkg::PIXEL_W),
        .PROD_SHIFT (dct2d_pkg::ROW_SHIFT),
        .RND_BITS   (dct2d_pkg::ROW_RND),
        .RES_W      (dct2d_pkg::ROW_W)
    ) row_mac (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_ctl    (row_ctl),
        .i_sample (i_pixel),
        .o_coef   (row_coef)
    );

    transpose_ram tm_ram (
        .clk     (clk),
        .i_wr    (tm_wr),
        .i_wdata (row_coef),
        .i_rd    (tm_rd),
        .o_rdata (tm_rdata)
    );

    dct_col_seq col_seq (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_page_done  (page_done),
        .i_page       (page),
        .o_tm_rd      (tm_rd),
        .o_mac_ctl    (col_ctl),
        .o_first_next (o_first_next),
        .o_valid      (o_valid)
    );

    dct_butterfly_mac #(
        .SAMPLE_W   (dct2d_pkg::ROW_W),
        .PROD_SHIFT (dct2d_pkg::COL_SHIFT),
        .RND_BITS   (dct2d_pkg::COL_RND),
        .RES_W      (dct2d_pkg::OUT_W)
    ) col_mac (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_ctl    (col_ctl),
        .i_sample (tm_rdata),
        .o_coef   (o_coef)
    );

endmodule

// File: hw/dct_col_seq.sv
/* column pass sequencer */
`timescale 1ns/1ps

module dct_col_seq (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_page_done,
    input  logic                i_page,
    output dct2d_pkg::tm_rd_t   o_tm_rd,
    output dct2d_pkg::mac_ctl_t o_mac_ctl,
    output logic                o_first_next,
    output logic                o_valid
);

    dct2d_pkg::col_state_e                state;
    logic                                 rd_page;   // page being read
    logic [5:0]                           rd_cnt;    // {column, row}
    logic                                 rd_act;
    logic [dct2d_pkg::COL_VALID_DLY-1:0]  act_dly;   // read-active history
    logic [dct2d_pkg::COL_VALID_DLY-2:0]  first_dly;
    logic [dct2d_pkg::COL_CAP_DLY-1:0]    cap_dly;

    assign rd_act = (state == dct2d_pkg::COL_READ);

    // transposed address, row varies fastest
    assign o_tm_rd.addr = {rd_page, rd_cnt[2:0], rd_cnt[5:3]};

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state   <= dct2d_pkg::COL_IDLE;
            rd_page <= 1'b0;
            rd_cnt  <= 6'd0;
        end else if (i_page_done) begin
            state   <= dct2d_pkg::COL_READ;   // also restarts at end of a page
            rd_page <= i_page;
            rd_cnt  <= 6'd0;
        end else if (rd_act) begin
            rd_cnt <= rd_cnt + 6'd1;
            if (rd_cnt == 6'd63) begin
                state <= dct2d_pkg::COL_IDLE;
            end
        end
    end

    // align mac control and flags to read latency
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            act_dly   <= '0;
            first_dly <= '0;
            cap_dly   <= '0;
        end else begin
            act_dly   <= {act_dly[dct2d_pkg::COL_VALID_DLY-2:0], rd_act};
            first_dly <= {first_dly[dct2d_pkg::COL_VALID_DLY-3:0],
                          rd_act && (rd_cnt == 6'd0)};
            cap_dly   <= {cap_dly[dct2d_pkg::COL_CAP_DLY-2:0],
                          rd_act && (rd_cnt[2:0] == 3'd7)};   // last row of a column
        end
    end

    assign o_mac_ctl.shift   = act_dly[dct2d_pkg::COL_SHIFT_DLY-1];   // data at mac
    assign o_mac_ctl.capture = cap_dly[dct2d_pkg::COL_CAP_DLY-1];
    assign o_first_next      = first_dly[dct2d_pkg::COL_VALID_DLY-2];
    assign o_valid           = act_dly[dct2d_pkg::COL_VALID_DLY-1];     // 64 in a row

endmodule

// File: hw/transpose_ram.sv
/* transpose memory, two pages */
`timescale 1ns/1ps

module transpose_ram (
    input  logic                          clk,
    input  dct2d_pkg::tm_wr_t             i_wr,
    input  logic [dct2d_pkg::ROW_W-1:0]   i_wdata,
    input  dct2d_pkg::tm_rd_t             i_rd,
    output logic [dct2d_pkg::ROW_W-1:0]   o_rdata
);

    // 2 pages x 64 words
    logic [dct2d_pkg::ROW_W-1:0] mem [2**dct2d_pkg::TM_ADDR_W];
    logic [dct2d_pkg::ROW_W-1:0] rd_q;   // array read register

    always_ff @(posedge clk) begin
        if (i_wr.we) begin
            mem[i_wr.addr] <= i_wdata;
        end
    end

    // synchronous read plus output register
    always_ff @(posedge clk) begin
        rd_q    <= mem[i_rd.addr];
        o_rdata <= rd_q;
    end

endmodule

// File: hw/dct_row_seq.sv
/* row pass sequencer */
`timescale 1ns/1ps

module dct_row_seq (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    output dct2d_pkg::mac_ctl_t o_mac_ctl,
    output dct2d_pkg::tm_wr_t   o_tm_wr,
    output logic                o_page_done,
    output logic                o_page
);

    logic                                busy;      // pixels 1..63 arriving
    logic [5:0]                          pix_cnt;   // index of next pixel
    logic [5:0]                          pix_idx;   // index of this cycle's pixel
    logic                                capture;
    logic [dct2d_pkg::ROW_WR_DLY-1:0]    cap_dly;   // capture to write start
    logic                                we;
    logic [5:0]                          wr_cnt;    // {row, coefficient}
    logic                                wr_page;

    assign pix_idx           = i_start ? 6'd0 : pix_cnt;
    assign o_mac_ctl.shift   = i_start | busy;   // pixel 0 comes with start
    assign o_mac_ctl.capture = capture;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            busy    <= 1'b0;
            pix_cnt <= 6'd0;
        end else if (i_start) begin
            busy    <= 1'b1;
            pix_cnt <= 6'd1;
        end else if (busy) begin
            busy    <= (pix_cnt != 6'd63);
            pix_cnt <= pix_cnt + 6'd1;
        end
    end

    // capture one cycle after every eighth pixel
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            capture <= 1'b0;
            cap_dly <= '0;
        end else begin
            capture <= o_mac_ctl.shift && (pix_idx[2:0] == 3'd7);
            cap_dly <= {cap_dly[dct2d_pkg::ROW_WR_DLY-2:0], capture};
        end
    end

    // write burst of eight per row, lands with mac output
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            we          <= 1'b0;
            wr_cnt      <= 6'd0;
            wr_page     <= 1'b0;
            o_page_done <= 1'b0;
            o_page      <= 1'b0;
        end else begin
            we          <= cap_dly[dct2d_pkg::ROW_WR_DLY-1] | (we & (wr_cnt[2:0] != 3'd7));
            o_page_done <= we & (wr_cnt == 6'd63);
            if (we) begin
                wr_cnt <= wr_cnt + 6'd1;
                if (wr_cnt == 6'd63) begin
                    wr_page <= ~wr_page;   // ping-pong
                    o_page  <= wr_page;    // page just filled
                end
            end
        end
    end

    assign o_tm_wr.we   = we;
    assign o_tm_wr.addr = {wr_page, wr_cnt};

endmodule

// File: hw/dct_butterfly_mac.sv
/* 1-D DCT butterfly and MAC */
`timescale 1ns/1ps

module dct_butterfly_mac #(
    parameter int SAMPLE_W   = 10,
    parameter int PROD_SHIFT = 9,
    parameter int RND_BITS   = 3,
    parameter int RES_W      = 16
) (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  dct2d_pkg::mac_ctl_t        i_ctl,
    input  logic signed [SAMPLE_W-1:0] i_sample,
    output logic signed [RES_W-1:0]    o_coef
);

    localparam int A_W    = SAMPLE_W + 1;                        // butterfly term
    localparam int PROD_W = A_W + dct2d_pkg::COEF_MAG_W;         // full product
    localparam int P_W    = PROD_W - PROD_SHIFT + 1;             // scaled, signed
    localparam int SUM_W  = P_W + 2;                             // four-term sum

    logic signed [SAMPLE_W-1:0] x      [8];   // x[0] newest sample
    logic signed [SAMPLE_W-1:0] xr     [8];   // captured set
    logic [2:0]                 k;            // output index in flight
    dct2d_pkg::bf_op_e          op;

    logic signed [A_W-1:0]      a      [4];
    logic [A_W-1:0]             a_mag  [4];
    logic [3:0]                 a_neg;

    logic [A_W-1:0]             mag_r  [4];   // stage 1
    logic [3:0]                 neg_r;
    dct2d_pkg::coef_t           coef_r [4];

    logic [PROD_W-1:0]          prod   [4];
    logic [P_W-2:0]             scaled [4];
    logic signed [P_W-1:0]      p_r    [4];   // stage 2

    logic signed [P_W:0]        s01_r;        // stage 3
    logic signed [P_W:0]        s23_r;
    logic signed [SUM_W-1:0]    sum_r;        // stage 4

    // sample shift register
    always_ff @(posedge clk) begin
        if (i_ctl.shift) begin
            x[0] <= i_sample;
            for (int i = 1; i < 8; i++) begin
                x[i] <= x[i-1];
            end
        end
        if (i_ctl.capture) begin
            xr <= x;   // old contents, before this cycle's shift
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            k <= 3'd0;
        end else if (i_ctl.capture) begin
            k <= 3'd0;
        end else begin
            k <= k + 3'd1;   // wraps onto next capture
        end
    end

    // butterfly, a_j from oldest/newest pairs
    always_comb begin
        op = k[0] ? dct2d_pkg::BF_DIFF : dct2d_pkg::BF_SUM;
        for (int j = 0; j < 4; j++) begin
            case (op)
                dct2d_pkg::BF_SUM:  a[j] = A_W'(xr[7-j]) + A_W'(xr[j]);
                dct2d_pkg::BF_DIFF: a[j] = A_W'(xr[7-j]) - A_W'(xr[j]);
            endcase
            a_neg[j] = a[j][A_W-1];
            a_mag[j] = a_neg[j] ? A_W'(-a[j]) : A_W'(a[j]);   // sign-magnitude
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < 4; j++) begin
            mag_r[j]  <= a_mag[j];
            neg_r[j]  <= a_neg[j];
            coef_r[j] <= dct2d_pkg::COEF_TABLE[k][j];   // row k of the basis
        end
    end

    // unsigned multiply, drop lsbs, then restore sign
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            prod[j]   = mag_r[j] * coef_r[j].mag;
            scaled[j] = prod[j][PROD_W-1:PROD_SHIFT];
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < 4; j++) begin
            if (neg_r[j] ^ coef_r[j].neg) begin
                p_r[j] <= -$signed({1'b0, scaled[j]});
            end else begin
                p_r[j] <= $signed({1'b0, scaled[j]});
            end
        end
    end

    // adder tree
    always_ff @(posedge clk) begin
        s01_r <= (P_W+1)'(p_r[0]) + (P_W+1)'(p_r[1]);
        s23_r <= (P_W+1)'(p_r[2]) + (P_W+1)'(p_r[3]);
        sum_r <= SUM_W'(s01_r) + SUM_W'(s23_r);
    end

    // round half up on the dropped bits
    assign o_coef = $signed(sum_r[RND_BITS +: RES_W] + RES_W'(sum_r[RND_BITS-1]));

endmodule

// File: hw/dct2d_pkg.sv
/* 2-D DCT shared definitions */
package dct2d_pkg;

    localparam int PIXEL_W    = 10;   // signed input pixel
    localparam int ROW_W      = 16;   // row-pass result, transpose word
    localparam int OUT_W      = 13;   // final coefficient
    localparam int TM_ADDR_W  = 7;    // page, row, column
    localparam int ROW_SHIFT  = 9;    // product lsbs dropped, row pass
    localparam int COL_SHIFT  = 14;   // product lsbs dropped, column pass
    localparam int ROW_RND    = 3;    // rounded-off sum bits, row pass
    localparam int COL_RND    = 8;    // rounded-off sum bits, column pass
    localparam int COEF_MAG_W = 16;

    localparam int MAC_LATENCY   = 5;                 // capture to first coefficient
    localparam int TM_RD_LATENCY = 2;                 // address to data
    localparam int ROW_WR_DLY    = MAC_LATENCY - 1;   // capture to write enable reg
    localparam int COL_SHIFT_DLY = TM_RD_LATENCY;     // read issue to sample at mac
    localparam int COL_CAP_DLY   = TM_RD_LATENCY + 1; // eighth read to capture
    localparam int COL_VALID_DLY = TM_RD_LATENCY + MAC_LATENCY + 8; // read to output

    // cosine magnitudes, scaled by 2^16
    localparam logic [COEF_MAG_W-1:0] C3 = 16'd54491;
    localparam logic [COEF_MAG_W-1:0] S3 = 16'd36410;
    localparam logic [COEF_MAG_W-1:0] C4 = 16'd46341;
    localparam logic [COEF_MAG_W-1:0] C6 = 16'd25080;
    localparam logic [COEF_MAG_W-1:0] S6 = 16'd60547;
    localparam logic [COEF_MAG_W-1:0] C7 = 16'd12785;
    localparam logic [COEF_MAG_W-1:0] S7 = 16'd64277;

    typedef struct packed {
        logic                  neg;   // coefficient is negative
        logic [COEF_MAG_W-1:0] mag;
    } coef_t;

    // row k = output index, column j = butterfly term a_j
    localparam coef_t [0:7][0:3] COEF_TABLE = '{
        '{'{1'b0, C4}, '{1'b0, C4}, '{1'b0, C4}, '{1'b0, C4}},
        '{'{1'b0, S7}, '{1'b0, C3}, '{1'b0, S3}, '{1'b0, C7}},
        '{'{1'b0, S6}, '{1'b0, C6}, '{1'b1, C6}, '{1'b1, S6}},
        '{'{1'b0, C3}, '{1'b1, C7}, '{1'b1, S7}, '{1'b1, S3}},
        '{'{1'b0, C4}, '{1'b1, C4}, '{1'b1, C4}, '{1'b0, C4}},
        '{'{1'b0, S3}, '{1'b1, S7}, '{1'b0, C7}, '{1'b0, C3}},
        '{'{1'b0, C6}, '{1'b1, S6}, '{1'b0, S6}, '{1'b1, C6}},
        '{'{1'b0, C7}, '{1'b1, S3}, '{1'b0, C3}, '{1'b1, S7}}
    };

    typedef enum logic {
        BF_SUM  = 1'b0,   // even outputs
        BF_DIFF = 1'b1    // odd outputs
    } bf_op_e;

    typedef enum logic {
        COL_IDLE = 1'b0,
        COL_READ = 1'b1
    } col_state_e;

    typedef struct packed {
        logic shift;     // new sample enters
        logic capture;   // latch eight samples, start eight outputs
    } mac_ctl_t;

    typedef struct packed {
        logic                 we;
        logic [TM_ADDR_W-1:0] addr;
    } tm_wr_t;

    typedef struct packed {
        logic [TM_ADDR_W-1:0] addr;
    } tm_rd_t;

endpackage
